//--- hdl/fp_config.svh
// fp compare config: fixed operand field widths and result queue depth
`ifndef FP_CONFIG_SVH
`define FP_CONFIG_SVH

// ==============================
// ieee 754 single precision
// ==============================
`define FP_WID        32
`define FP_EXP_WID    8
`define FP_MAN_WID    23

// result entries, also the upstream credits handed out after reset
`define FP_QUEUE_DEPTH 4

`endif

//--- hdl/fp_pkg.sv
// fp compare types: vector typedefs shared by the pipeline and its testbench
`include "fp_config.svh"

package fp_pkg;

	// ==============================
	// operand fields
	// ==============================
	// one raw operand word
	typedef logic [`FP_WID-1:0]     fp_word_t;
	// biased exponent
	typedef logic [`FP_EXP_WID-1:0] fp_exp_t;
	// stored fraction, hidden bit not included
	typedef logic [`FP_MAN_WID-1:0] fp_man_t;

	// ==============================
	// results and flow control
	// ==============================
	// bit 0 eq, bit 1 lt, bit 2 le, bit 3 magnitude lt, bit 4 unordered
	typedef logic [4:0] cmp_flags_t;

	// must reach FP_QUEUE_DEPTH, so one bit more than the pointer
	typedef logic [$clog2(`FP_QUEUE_DEPTH+1)-1:0] credit_count_t;

endpackage

//--- hdl/fp_decomp.sv
// fp decompose: splits an operand into fields and flags zero, nan and snan
`include "fp_config.svh"

module fp_decomp
(
	input  fp_pkg::fp_word_t i,
	output logic             sgn,
	output fp_pkg::fp_exp_t  exp,
	output fp_pkg::fp_man_t  man,
	output logic             zero,
	output logic             nan,
	output logic             snan
);

	logic exp_zero;
	logic exp_ones;
	logic man_zero;

	// field split, sign on top then exponent then fraction
	assign sgn = i[`FP_WID-1];
	assign exp = i[`FP_WID-2 -: `FP_EXP_WID];
	assign man = i[`FP_MAN_WID-1:0];

	// exponent and fraction extremes
	assign exp_zero = (exp == '0);
	assign exp_ones = &exp;
	assign man_zero = (man == '0);

	// either signed zero, denormals count as nonzero
	assign zero = exp_zero & man_zero;

	// infinity has a zero fraction so it is not a nan
	assign nan = exp_ones & ~man_zero;

	// quiet bit is the fraction msb
	// a nan with it clear is signalling
	assign snan = nan & ~man[`FP_MAN_WID-1];

endmodule

//--- hdl/fp_classify_stage.sv
// fp classify stage: decomposes both operands and registers fields and classes
`include "fp_config.svh"

module fp_classify_stage
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                in_valid,
	input  fp_pkg::fp_word_t                    a,
	input  fp_pkg::fp_word_t                    b,
	output logic                                s1_valid,
	output logic                                s1_sa,
	output logic                                s1_sb,
	output logic [`FP_EXP_WID+`FP_MAN_WID-1:0] s1_mag_a,
	output logic [`FP_EXP_WID+`FP_MAN_WID-1:0] s1_mag_b,
	output logic                                s1_za,
	output logic                                s1_zb,
	output logic                                s1_nan_a,
	output logic                                s1_nan_b,
	output logic                                s1_snan_a,
	output logic                                s1_snan_b,
	output logic                                s1_same
);

	import fp_pkg::*;

	logic    sgn_a, sgn_b;
	fp_exp_t exp_a, exp_b;
	fp_man_t man_a, man_b;
	logic    zero_a, zero_b;
	logic    nan_a, nan_b;
	logic    snan_a, snan_b;

	// ==============================
	// operand decode
	// ==============================
	fp_decomp i_decomp_a
	(
		.i(a), .sgn(sgn_a), .exp(exp_a), .man(man_a),
		.zero(zero_a), .nan(nan_a), .snan(snan_a)
	);

	fp_decomp i_decomp_b
	(
		.i(b), .sgn(sgn_b), .exp(exp_b), .man(man_b),
		.zero(zero_b), .nan(nan_b), .snan(snan_b)
	);

	// ==============================
	// stage register
	// ==============================
	// valid is the only control bit here
	always_ff @(posedge clk)
	begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	// payload only moves on an accepted pair
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			s1_sa     <= sgn_a;
			s1_sb     <= sgn_b;
			// exponent above fraction orders magnitudes as integers
			s1_mag_a  <= {exp_a, man_a};
			s1_mag_b  <= {exp_b, man_b};
			s1_za     <= zero_a;
			s1_zb     <= zero_b;
			s1_nan_a  <= nan_a;
			s1_nan_b  <= nan_b;
			s1_snan_a <= snan_a;
			s1_snan_b <= snan_b;
			// raw word match, stands in for the operands downstream
			s1_same   <= (a == b);
		end
	end

endmodule

//--- hdl/fp_compare_stage.sv
// fp compare stage: forms the five comparison flags and registers them
`include "fp_config.svh"

module fp_compare_stage
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                s1_valid,
	input  logic                                s1_sa,
	input  logic                                s1_sb,
	input  logic [`FP_EXP_WID+`FP_MAN_WID-1:0] s1_mag_a,
	input  logic [`FP_EXP_WID+`FP_MAN_WID-1:0] s1_mag_b,
	input  logic                                s1_za,
	input  logic                                s1_zb,
	input  logic                                s1_nan_a,
	input  logic                                s1_nan_b,
	input  logic                                s1_snan_a,
	input  logic                                s1_snan_b,
	input  logic                                s1_same,
	output logic                                s2_valid,
	output fp_pkg::cmp_flags_t                  s2_flags,
	output logic                                s2_nan,
	output logic                                s2_snan
);

	import fp_pkg::*;

	logic       unord;
	logic       both_zero;
	logic       mag_lt, mag_gt;
	logic       eq, lt;
	cmp_flags_t flags;

	// ==============================
	// flag logic
	// ==============================
	assign unord     = s1_nan_a | s1_nan_b;
	assign both_zero = s1_za & s1_zb;

	// +0 and -0 differ in the sign bit only
	assign eq = ~unord & (both_zero | s1_same);

	// sign ignored
	assign mag_lt = (s1_mag_a < s1_mag_b);
	assign mag_gt = (s1_mag_a > s1_mag_b);

	// mixed signs: negative a is less, except for the two zeros
	// same sign: negative reverses the magnitude order
	always_comb
	begin
		if (s1_sa ^ s1_sb)
			lt = s1_sa & ~both_zero;
		else if (s1_sa)
			lt = mag_gt;
		else
			lt = mag_lt;
		lt = lt & ~unord;
	end

	assign flags = {unord, mag_lt, lt | eq, lt, eq};

	// ==============================
	// stage register
	// ==============================
	always_ff @(posedge clk)
	begin
		if (rst)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid;
	end

	always_ff @(posedge clk)
	begin
		if (s1_valid)
		begin
			s2_flags <= flags;
			s2_nan   <= unord;
			s2_snan  <= s1_snan_a | s1_snan_b;
		end
	end

endmodule

//--- hdl/fp_result_queue.sv
// fp result queue: buffers results and runs credit flow control on both sides
`include "fp_config.svh"

module fp_result_queue
(
	input  logic               clk,
	input  logic               rst,
	input  logic               s2_valid,
	input  fp_pkg::cmp_flags_t s2_flags,
	input  logic               s2_nan,
	input  logic               s2_snan,
	input  logic               out_credit,
	output logic               out_valid,
	output fp_pkg::cmp_flags_t flags,
	output logic               nan,
	output logic               snan,
	output logic               in_credit
);

	import fp_pkg::*;

	localparam int DEPTH   = `FP_QUEUE_DEPTH;
	localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// entry storage
	cmp_flags_t mem_flags [DEPTH];
	logic       mem_nan   [DEPTH];
	logic       mem_snan  [DEPTH];

	logic [PTR_WID-1:0] wr_ptr;
	logic [PTR_WID-1:0] rd_ptr;
	credit_count_t      count;
	// downstream credits held
	credit_count_t      dn_credit;
	credit_count_t      credit_free;
	logic               pop;

	// ==============================
	// pop decision
	// ==============================
	// a credit under a live out_valid is already spent
	assign credit_free = dn_credit - credit_count_t'(out_valid);
	assign pop         = (count != '0) && (credit_free != '0);

	// ==============================
	// buffer
	// ==============================
	// upstream credits stop overflow, so writes are never refused
	always_ff @(posedge clk)
	begin
		if (s2_valid)
		begin
			mem_flags[wr_ptr] <= s2_flags;
			mem_nan[wr_ptr]   <= s2_nan;
			mem_snan[wr_ptr]  <= s2_snan;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (s2_valid)
				wr_ptr <= (wr_ptr == PTR_WID'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_WID'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			count <= count + credit_count_t'(s2_valid) - credit_count_t'(pop);
		end
	end

	// ==============================
	// downstream credits and output
	// ==============================
	// grants past the counter range are dropped
	always_ff @(posedge clk)
	begin
		if (rst)
			dn_credit <= '0;
		else if (out_credit && !out_valid)
		begin
			if (dn_credit != '1)
				dn_credit <= dn_credit + 1'b1;
		end
		else if (!out_credit && out_valid)
			dn_credit <= dn_credit - 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= pop;
	end

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			flags <= mem_flags[rd_ptr];
			nan   <= mem_nan[rd_ptr];
			snan  <= mem_snan[rd_ptr];
		end
	end

	// the slot freed by each result goes straight back upstream
	assign in_credit = out_valid;

endmodule

//--- hdl/fp_compare_pipe.sv
// fp compare pipe: classify, compare and result queue stages in a row
`include "fp_config.svh"

module fp_compare_pipe
(
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid,
	input  fp_pkg::fp_word_t   a,
	input  fp_pkg::fp_word_t   b,
	input  logic               out_credit,
	output logic               out_valid,
	output fp_pkg::cmp_flags_t flags,
	output logic               nan,
	output logic               snan,
	output logic               in_credit
);

	import fp_pkg::*;

	// ==============================
	// stage 1 to stage 2
	// ==============================
	logic                                s1_valid;
	logic                                s1_sa, s1_sb;
	logic [`FP_EXP_WID+`FP_MAN_WID-1:0] s1_mag_a, s1_mag_b;
	logic                                s1_za, s1_zb;
	logic                                s1_nan_a, s1_nan_b;
	logic                                s1_snan_a, s1_snan_b;
	logic                                s1_same;

	// stage 2 to queue
	logic       s2_valid;
	cmp_flags_t s2_flags;
	logic       s2_nan, s2_snan;

	fp_classify_stage i_classify
	(
		.clk(clk), .rst(rst), .in_valid(in_valid), .a(a), .b(b),
		.s1_valid(s1_valid), .s1_sa(s1_sa), .s1_sb(s1_sb),
		.s1_mag_a(s1_mag_a), .s1_mag_b(s1_mag_b), .s1_za(s1_za), .s1_zb(s1_zb),
		.s1_nan_a(s1_nan_a), .s1_nan_b(s1_nan_b),
		.s1_snan_a(s1_snan_a), .s1_snan_b(s1_snan_b), .s1_same(s1_same)
	);

	fp_compare_stage i_compare
	(
		.clk(clk), .rst(rst),
		.s1_valid(s1_valid), .s1_sa(s1_sa), .s1_sb(s1_sb),
		.s1_mag_a(s1_mag_a), .s1_mag_b(s1_mag_b), .s1_za(s1_za), .s1_zb(s1_zb),
		.s1_nan_a(s1_nan_a), .s1_nan_b(s1_nan_b),
		.s1_snan_a(s1_snan_a), .s1_snan_b(s1_snan_b), .s1_same(s1_same),
		.s2_valid(s2_valid), .s2_flags(s2_flags), .s2_nan(s2_nan), .s2_snan(s2_snan)
	);

	// latency past this point depends on the consumer's credits
	fp_result_queue i_queue
	(
		.clk(clk), .rst(rst),
		.s2_valid(s2_valid), .s2_flags(s2_flags), .s2_nan(s2_nan), .s2_snan(s2_snan),
		.out_credit(out_credit), .out_valid(out_valid),
		.flags(flags), .nan(nan), .snan(snan), .in_credit(in_credit)
	);

endmodule

//--- testbench/fp_compare_asserts.sv
// fp compare checks: credit protocol and flag consistency seen at the pipe ports
module fp_compare_asserts
(
	input logic               clk,
	input logic               rst,
	input logic               in_valid,
	input logic               out_credit,
	input logic               out_valid,
	input fp_pkg::cmp_flags_t flags,
	input logic               nan,
	input logic               in_credit
);

	timeunit 1ns;
	timeprecision 1ps;

	// running totals of both credit loops since the last reset
	int unsigned accepted;
	int unsigned returned;
	int unsigned granted;
	int unsigned spent;
	int unsigned fail_count = 0;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			accepted <= 0;
			returned <= 0;
			granted  <= 0;
			spent    <= 0;
		end
		else
		begin
			if (in_valid)
				accepted <= accepted + 1;
			if (in_credit)
				returned <= returned + 1;
			if (out_credit)
				granted <= granted + 1;
			if (out_valid)
				spent <= spent + 1;
		end
	end

	// ==============================
	// credit protocol
	// ==============================
	// each result spends a grant that is not used up yet
	a_out_credit: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> spent < granted)
	else
	begin
		$error("out_valid raised with no downstream credit left");
		fail_count++;
	end

	// a slot only comes back for a pair that went in
	a_in_credit: assert property (@(posedge clk) disable iff (rst)
		in_credit |-> returned < accepted)
	else
	begin
		$error("more in_credit pulses than accepted pairs");
		fail_count++;
	end

	a_reset_quiet: assert property (@(posedge clk)
		rst && $past(rst) |-> !out_valid && !in_credit)
	else
	begin
		$error("out_valid or in_credit high during reset");
		fail_count++;
	end

	// ==============================
	// flag consistency
	// ==============================
	a_eq_lt: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> !(flags[0] && flags[1]))
	else
	begin
		$error("equal and less both set");
		fail_count++;
	end

	a_le: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> flags[2] == (flags[0] || flags[1]))
	else
	begin
		$error("less or equal differs from less or equal");
		fail_count++;
	end

	// unordered rules out equal and less, and a nan is always unordered
	a_unord: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> (!flags[4] || !(flags[0] || flags[1])) && (!nan || flags[4]))
	else
	begin
		$error("unordered result with equal or less, or nan without unordered");
		fail_count++;
	end

endmodule

bind fp_compare_pipe fp_compare_asserts i_asserts
(
	.clk(clk), .rst(rst), .in_valid(in_valid), .out_credit(out_credit),
	.out_valid(out_valid), .flags(flags), .nan(nan), .in_credit(in_credit)
);

//--- testbench/fp_compare_tb.sv
// fp compare testbench drives credit flow stimulus and checks it against a reference model
`include "fp_config.svh"

module fp_compare_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import fp_pkg::*;

	localparam int DEPTH = `FP_QUEUE_DEPTH;
	localparam int LIMIT = 200;

	logic       clk;
	logic       rst;
	logic       in_valid;
	fp_word_t   a;
	fp_word_t   b;
	logic       out_credit;
	logic       out_valid;
	cmp_flags_t flags;
	logic       nan;
	logic       snan;
	logic       in_credit;

	// expected {snan, nan, flags} with the oldest in front
	logic [6:0]  exp_q[$];
	logic [15:0] lfsr_state = 16'd67;
	int          sent, returned, results, checks, errors, mark;
	bit          hung;

	fp_compare_pipe i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==============================
	// reference model
	// ==============================
	function automatic logic [6:0] ref_compare(input fp_word_t x, input fp_word_t y);
		logic nan_x, nan_y, snan_x, snan_y;
		logic zeros, unord, mag_lt, eq, lt;
		nan_x  = (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
		nan_y  = (y[30:23] == 8'hff) && (y[22:0] != 23'd0);
		// quiet bit clear means signalling
		snan_x = nan_x && !x[22];
		snan_y = nan_y && !y[22];
		zeros  = (x[30:0] == 31'd0) && (y[30:0] == 31'd0);
		unord  = nan_x || nan_y;
		mag_lt = x[30:0] < y[30:0];
		eq     = !unord && (zeros || x == y);
		if (unord || zeros)
			lt = 1'b0;
		else if (x[31] != y[31])
			lt = x[31];
		else if (x[31])
			lt = y[30:0] < x[30:0];
		else
			lt = mag_lt;
		return {snan_x || snan_y, unord, unord, mag_lt, lt || eq, lt, eq};
	endfunction

	// 16 bit fibonacci lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output fp_word_t w);
		w = '0;
		repeat (n)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	task automatic compare_value(input string name, input int got, input int want);
		checks++;
		if (got != want)
		begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
			errors++;
		end
	endtask

	// ==============================
	// result monitor
	// ==============================
	// registered outputs read before this edge updates them
	always @(posedge clk)
	begin : monitor
		logic [6:0] want;
		if (!rst && in_credit)
			returned++;
		if (!rst && out_valid)
		begin
			results++;
			if (exp_q.size() == 0)
			begin
				$display("at %0t: a result came out with nothing outstanding", $time);
				errors++;
			end
			else
			begin
				want = exp_q.pop_front();
				compare_value("flags", int'(flags), int'(want[4:0]));
				compare_value("nan", int'(nan), int'(want[5]));
				compare_value("snan", int'(snan), int'(want[6]));
			end
		end
	end

	// ==============================
	// drivers
	// ==============================
	task automatic apply_reset();
		rst        = 1'b1;
		in_valid   = 1'b0;
		out_credit = 1'b0;
		repeat (16) @(negedge clk);
		sent     = 0;
		returned = 0;
		results  = 0;
		rst      = 1'b0;
	endtask

	// spends one upstream credit and waits for one to come back if none is left
	task automatic send_pair(input fp_word_t x, input fp_word_t y);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!hung && sent - returned >= DEPTH)
		begin
			in_valid = 1'b0;
			waited++;
			if (waited > LIMIT)
			begin
				$display("at %0t: timeout, no upstream credit came back", $time);
				errors++;
				hung = 1'b1;
			end
			else
				@(negedge clk);
		end
		if (!hung)
		begin
			in_valid = 1'b1;
			a        = x;
			b        = y;
			sent++;
			exp_q.push_back(ref_compare(x, y));
		end
	endtask

	task automatic idle_for(input int n);
		repeat (n)
		begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	task automatic grant_once();
		@(negedge clk);
		in_valid   = 1'b0;
		out_credit = 1'b1;
		@(negedge clk);
		out_credit = 1'b0;
	endtask

	// grants a credit every gap cycles until all expected results are out
	task automatic drain(input int gap);
		int waited;
		waited = 0;
		@(negedge clk);
		in_valid = 1'b0;
		while (!hung && exp_q.size() != 0)
		begin
			out_credit = (gap != 0) && (waited % gap == 0);
			waited++;
			@(negedge clk);
			if (waited > LIMIT)
			begin
				$display("at %0t: timeout, results did not drain", $time);
				errors++;
				hung = 1'b1;
			end
		end
		out_credit = 1'b0;
	endtask

	task automatic report(input string name);
		$display("test %s done, %0d errors", name, errors - mark);
		mark = errors;
	endtask

	// ==============================
	// test sequence
	// ==============================
	initial
	begin
		fp_word_t x;
		fp_word_t y;
		fp_word_t pick;
		in_valid   = 1'b0;
		a          = '0;
		b          = '0;
		out_credit = 1'b0;
		apply_reset();

		// one pair held in the queue until the first grant
		send_pair(32'h3f80_0000, 32'h4000_0000);
		idle_for(12);
		compare_value("results before any credit", results, 0);
		compare_value("in_credit pulses before any credit", returned, 0);
		drain(4);
		report("no credit hold");

		out_credit = 1'b1;
		send_pair(32'h0000_0000, 32'h8000_0000);
		send_pair(32'h3f80_0000, 32'h3f80_0000);
		// -2 against -1 and then swapped so magnitude less disagrees with less
		send_pair(32'hc000_0000, 32'hbf80_0000);
		send_pair(32'hbf80_0000, 32'hc000_0000);
		send_pair(32'hbf80_0000, 32'h3f00_0000);
		send_pair(32'h7f80_0000, 32'h7f80_0000);
		drain(1);
		report("directed");

		out_credit = 1'b1;
		send_pair(32'h7fc0_0000, 32'h3f80_0000);
		send_pair(32'h3f80_0000, 32'h7fc0_0000);
		send_pair(32'h7fc0_0000, 32'h7fc0_0000);
		send_pair(32'h7f80_0001, 32'h3f80_0000);
		send_pair(32'h3f80_0000, 32'hffa0_0000);
		drain(1);
		report("nan");

		out_credit = 1'b1;
		repeat (200)
		begin
			take_bits(32, x);
			take_bits(32, y);
			take_bits(2, pick);
			// now and then an identical pair
			send_pair(x, (pick == 3) ? x : y);
		end
		drain(1);
		report("random stream");

		// fresh reset clears the credits piled up by the stream
		apply_reset();
		repeat (DEPTH)
		begin
			take_bits(32, x);
			take_bits(32, y);
			send_pair(x, y);
		end
		idle_for(12);
		compare_value("results while credits withheld", results, 0);
		compare_value("upstream credits held", DEPTH - (sent - returned), 0);
		repeat (2 * DEPTH)
		begin
			grant_once();
			take_bits(32, x);
			take_bits(32, y);
			send_pair(x, y);
		end
		drain(3);
		// a spare grant must find the pipe empty
		grant_once();
		idle_for(8);
		compare_value("results after back-pressure", results, 3 * DEPTH);
		compare_value("in_credit pulses", returned, sent);
		report("back-pressure");

		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, i_dut.i_asserts.fail_count);
		if (errors == 0 && i_dut.i_asserts.fail_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- project.f
+incdir+hdl
hdl/fp_pkg.sv
hdl/fp_decomp.sv
hdl/fp_classify_stage.sv
hdl/fp_compare_stage.sv
hdl/fp_result_queue.sv
hdl/fp_compare_pipe.sv
testbench/fp_compare_asserts.sv
testbench/fp_compare_tb.sv

//--- Makefile
TOP = fp_compare_tb
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "run failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "run did not complete"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
